// File: common/cache_pkg.sv
`default_nettype none

package cache_pkg;

  // word and line geometry
  localparam int word_bits      = 4;
  localparam int offset_bits    = 2;
  localparam int index_bits     = 3;
  localparam int addr_bits      = 10;
  localparam int tag_bits       = addr_bits - index_bits - offset_bits;
  localparam int line_addr_bits = addr_bits - offset_bits;

  localparam int words_per_line = 2 ** offset_bits;
  localparam int line_bits      = word_bits * words_per_line;

  // storage depths
  localparam int num_lines = 2 ** index_bits;
  localparam int mem_lines = 2 ** line_addr_bits;

  // backing memory pacing
  localparam int fetch_delay = 3;
  localparam int delay_bits  = $clog2(fetch_delay + 1);

  typedef logic [word_bits-1:0]      word_t;
  typedef logic [addr_bits-1:0]      addr_t;
  typedef logic [line_addr_bits-1:0] line_addr_t;
  typedef logic [tag_bits-1:0]       tag_t;
  typedef logic [index_bits-1:0]     index_t;
  typedef logic [offset_bits-1:0]    offset_t;
  typedef logic [line_bits-1:0]      line_t;

  // word 0 sits in the low bits of a line
  function automatic word_t get_word(input line_t line_val, input offset_t offset);
    word_t word_val;
    word_val = line_val[offset*word_bits +: word_bits];
    return word_val;
  endfunction

endpackage

`default_nettype wire

// File: common/line_fetch_if.sv
`default_nettype none

interface line_fetch_if
  import cache_pkg::*;
();

  // request held until fetch_ready
  logic       fetch_valid;
  line_addr_t fetch_addr;

  // line_data follows one cycle after acceptance
  logic       fetch_ready;
  line_t      line_data;

  modport requester (
    output fetch_valid,
    output fetch_addr,
    input  fetch_ready,
    input  line_data
  );

  modport responder (
    input  fetch_valid,
    input  fetch_addr,
    output fetch_ready,
    output line_data
  );

endinterface

`default_nettype wire

// File: cache/cache_direct_mapped.sv
`default_nettype none

module cache_direct_mapped
  import cache_pkg::*;
(
  input  logic            clk,
  input  logic            reset,

  input  logic            read_valid,
  input  addr_t           read_addr,
  output logic            read_ready,
  output word_t           read_data,

  input  logic            flush,

  line_fetch_if.requester fetch
);

  typedef enum logic [1:0] {
    st_idle,
    st_fetch,
    st_install
  } state_t;

  state_t state;
  state_t state_next;

  // fields of the live request
  tag_t    req_tag;
  index_t  req_index;
  offset_t req_offset;

  // fields of the request in flight
  tag_t    tag_q;
  index_t  index_q;
  offset_t offset_q;

  tag_t                 tag_store  [num_lines];
  line_t                line_store [num_lines];
  logic [num_lines-1:0] valid_q;

  line_t line_rd_q;
  logic  hit;

  assign req_tag    = read_addr[addr_bits-1 -: tag_bits];
  assign req_index  = read_addr[offset_bits +: index_bits];
  assign req_offset = read_addr[offset_bits-1:0];

  assign hit = valid_q[req_index] && (tag_store[req_index] == req_tag);

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      state   <= st_idle;
      valid_q <= '0;
    end
    else
    begin
      state <= state_next;
      if (flush)
      begin
        valid_q <= '0;
      end
      else if (state == st_install)
      begin
        valid_q[index_q] <= 1'b1;
      end
    end
  end

  // request fields latched while idle for the miss path
  always_ff @(posedge clk)
  begin
    if (state == st_idle && read_valid)
    begin
      tag_q    <= req_tag;
      index_q  <= req_index;
      offset_q <= req_offset;
    end
  end

  // registered read for hits
  always_ff @(posedge clk)
  begin
    line_rd_q <= line_store[req_index];
    // install writes the fetched line
    if (state == st_install)
    begin
      tag_store[index_q]  <= tag_q;
      line_store[index_q] <= fetch.line_data;
    end
  end

  always_comb
  begin
    state_next = state;
    case (state)
      st_idle:
      begin
        if (read_valid && !hit)
        begin
          state_next = st_fetch;
        end
      end
      st_fetch:
      begin
        if (fetch.fetch_ready)
        begin
          state_next = st_install;
        end
      end
      st_install:
      begin
        state_next = st_idle;
      end
      default:
      begin
        state_next = st_idle;
      end
    endcase
  end

  always_comb
  begin
    read_ready = 1'b0;
    read_data  = get_word(line_rd_q, offset_q);
    case (state)
      st_idle:
      begin
        read_ready = read_valid && hit;
      end
      st_fetch:
      begin
        // line_data follows next cycle so the read retires now
        read_ready = fetch.fetch_ready;
      end
      st_install:
      begin
        read_data = get_word(fetch.line_data, offset_q);
      end
      default:
      begin
        read_ready = 1'b0;
      end
    endcase
  end

  assign fetch.fetch_valid = (state == st_fetch);
  assign fetch.fetch_addr  = {tag_q, index_q};

  fetch_held_until_ready: assert property (
    @(posedge clk) disable iff (reset)
    fetch.fetch_valid && !fetch.fetch_ready |=> fetch.fetch_valid
  ) else $error("fetch_valid dropped before fetch_ready");

  read_addr_stable: assert property (
    @(posedge clk) disable iff (reset)
    read_valid && !read_ready |=> read_valid && $stable(read_addr)
  ) else $error("read request changed before acceptance");

  flush_only_idle: assert property (
    @(posedge clk) disable iff (reset)
    flush |-> state == st_idle
  ) else $error("flush while a miss is pending");

endmodule

`default_nettype wire

// File: hw/line_memory.sv
`default_nettype none

module line_memory
  import cache_pkg::*;
(
  input  logic            clk,
  input  logic            reset,

  input  logic            write_en,
  input  addr_t           write_addr,
  input  word_t           write_data,

  line_fetch_if.responder fetch
);

  line_t mem [mem_lines];

  line_addr_t write_line;
  offset_t    write_offset;

  logic [delay_bits-1:0] delay_count;
  logic                  accept;
  line_t                 line_q;

  assign write_line   = write_addr[addr_bits-1 -: line_addr_bits];
  assign write_offset = write_addr[offset_bits-1:0];

  // single word update inside one line
  always_ff @(posedge clk)
  begin
    if (write_en)
    begin
      mem[write_line][write_offset*word_bits +: word_bits] <= write_data;
    end
  end

  // counts cycles of a continuous fetch request
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      delay_count <= '0;
    end
    else if (!fetch.fetch_valid || accept)
    begin
      delay_count <= '0;
    end
    else
    begin
      delay_count <= delay_count + 1'b1;
    end
  end

  // ready on the fetch_delay-th cycle of the request
  assign accept = fetch.fetch_valid && (delay_count == delay_bits'(fetch_delay - 1));

  always_ff @(posedge clk)
  begin
    if (accept)
    begin
      line_q <= mem[fetch.fetch_addr];
    end
  end

  assign fetch.fetch_ready = accept;
  assign fetch.line_data   = line_q;

  fetch_addr_stable: assert property (
    @(posedge clk) disable iff (reset)
    fetch.fetch_valid && !fetch.fetch_ready |=> fetch.fetch_valid && $stable(fetch.fetch_addr)
  ) else $error("fetch request changed before fetch_ready");

endmodule

`default_nettype wire

// File: hw/cache_subsystem_top.sv
`default_nettype none

module cache_subsystem_top
  import cache_pkg::*;
(
  input  logic  clk,
  input  logic  reset,

  // requestor side
  input  logic  read_valid,
  input  addr_t read_addr,
  output logic  read_ready,
  output word_t read_data,

  // invalidates all lines while idle
  input  logic  flush,

  // preload port of the backing memory
  input  logic  mem_write_en,
  input  addr_t mem_write_addr,
  input  word_t mem_write_data
);

  line_fetch_if fetch_bus ();

  cache_direct_mapped u_cache (
    .clk        (clk),
    .reset      (reset),
    .read_valid (read_valid),
    .read_addr  (read_addr),
    .read_ready (read_ready),
    .read_data  (read_data),
    .flush      (flush),
    .fetch      (fetch_bus.requester)
  );

  line_memory u_memory (
    .clk        (clk),
    .reset      (reset),
    .write_en   (mem_write_en),
    .write_addr (mem_write_addr),
    .write_data (mem_write_data),
    .fetch      (fetch_bus.responder)
  );

endmodule

`default_nettype wire

// File: sim/clock_gen.sv
`default_nettype none

module clock_gen (
  output logic clk,
  output logic reset
);

  timeunit 1ns;
  timeprecision 1ps;

  localparam int half_period  = 2;
  localparam int reset_cycles = 4;

  initial
  begin
    clk = 1'b0;
    forever #half_period clk = ~clk;
  end

  // release on a falling edge
  initial
  begin
    reset = 1'b1;
    repeat (reset_cycles) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
  end

endmodule

`default_nettype wire

// File: sim/cache_tb.sv
`default_nettype none

module cache_tb
  import cache_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int read_timeout  = 20;
  localparam int reset_timeout = 20;
  localparam int random_reads  = 200;
  localparam int mem_words     = 2 ** addr_bits;
  // one latch cycle and fetch_delay-1 fetch cycles before fetch_ready
  localparam int miss_wait_cycles = fetch_delay;
  localparam logic [31:0] lfsr_seed = 32'h4227_65db;
  localparam logic [31:0] lfsr_taps = 32'h8020_0003;

  logic  clk;
  logic  reset;
  logic  read_valid;
  addr_t read_addr;
  logic  read_ready;
  word_t read_data;
  logic  flush;
  logic  mem_write_en;
  addr_t mem_write_addr;
  word_t mem_write_data;

  // reference memory and the model's view of each cache line
  word_t                ref_mem          [mem_words];
  line_addr_t           cached_line_addr [num_lines];
  word_t                cached_words     [num_lines][words_per_line];
  logic [num_lines-1:0] cached_valid;

  logic        expect_hit;
  word_t       expected_word;
  int          wait_cycles;
  int          error_count;
  int          timeout_count;
  int          read_count;
  int          hit_count;
  logic [31:0] lfsr_state;

  clock_gen u_clock_gen (
    .clk   (clk),
    .reset (reset)
  );

  cache_subsystem_top u_cache_subsystem_top (
    .clk            (clk),
    .reset          (reset),
    .read_valid     (read_valid),
    .read_addr      (read_addr),
    .read_ready     (read_ready),
    .read_data      (read_data),
    .flush          (flush),
    .mem_write_en   (mem_write_en),
    .mem_write_addr (mem_write_addr),
    .mem_write_data (mem_write_data)
  );

  // cycles a request has waited without acceptance
  always_ff @(posedge clk)
  begin
    if (reset || !read_valid || read_ready)
    begin
      wait_cycles <= 0;
    end
    else
    begin
      wait_cycles <= wait_cycles + 1;
    end
  end

  read_data_matches: assert property (
    @(posedge clk) disable iff (reset)
    read_valid && read_ready |=> read_data == expected_word
  ) else
  begin
    error_count++;
    $display("mismatch at %0t: read_data got %h expected %h",
             $time, $sampled(read_data), $sampled(expected_word));
  end

  accept_latency_matches: assert property (
    @(posedge clk) disable iff (reset)
    read_valid && read_ready |-> wait_cycles == (expect_hit ? 0 : miss_wait_cycles)
  ) else
  begin
    error_count++;
    $display("mismatch at %0t: read_ready latency got %0d expected %0d",
             $time, $sampled(wait_cycles), expect_hit ? 0 : miss_wait_cycles);
  end

  function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    logic [31:0] next_state;
    next_state = state >> 1;
    if (state[0])
    begin
      next_state = next_state ^ lfsr_taps;
    end
    return next_state;
  endfunction

  task automatic take_bits(input int count, output logic [31:0] value);
    int i;
    value = '0;
    for (i = 0; i < count; i++)
    begin
      value      = {value[30:0], lfsr_state[0]};
      lfsr_state = lfsr_next(lfsr_state);
    end
  endtask

  // folds every address bit into the word
  function automatic word_t fill_pattern(input addr_t addr);
    word_t value;
    value = addr[3:0] ^ addr[7:4] ^ word_t'(addr[9:8]) ^ 4'h5;
    return value;
  endfunction

  task automatic finish_run();
    $display("reads=%0d hits=%0d errors=%0d timeouts=%0d",
             read_count, hit_count, error_count, timeout_count);
    if (error_count == 0 && timeout_count == 0)
    begin
      $display("SIMULATION PASSED");
    end
    else
    begin
      $display("SIMULATION FAILED");
    end
    $finish;
  endtask

  task automatic write_word(input addr_t addr, input word_t data);
    mem_write_en   = 1'b1;
    mem_write_addr = addr;
    mem_write_data = data;
    ref_mem[addr]  = data;
    @(negedge clk);
    mem_write_en   = 1'b0;
  endtask

  task automatic flush_cache();
    flush        = 1'b1;
    cached_valid = '0;
    @(negedge clk);
    flush        = 1'b0;
  endtask

  task automatic do_read(input addr_t addr);
    line_addr_t line_addr;
    index_t     index;
    offset_t    offset;
    int         cycles;
    int         i;
    line_addr = addr[addr_bits-1 -: line_addr_bits];
    index     = addr[offset_bits +: index_bits];
    offset    = addr[offset_bits-1:0];
    // hit means same line at that index and loaded since the last flush
    expect_hit = cached_valid[index] && (cached_line_addr[index] == line_addr);
    if (expect_hit)
    begin
      expected_word = cached_words[index][offset];
      hit_count++;
    end
    else
    begin
      expected_word           = ref_mem[addr];
      cached_valid[index]     = 1'b1;
      cached_line_addr[index] = line_addr;
      for (i = 0; i < words_per_line; i++)
      begin
        cached_words[index][i] = ref_mem[{line_addr, offset_t'(i)}];
      end
    end
    read_count++;
    read_valid = 1'b1;
    read_addr  = addr;
    cycles     = 0;
    #1;
    while (!read_ready && cycles < read_timeout)
    begin
      @(negedge clk);
      #1;
      cycles++;
    end
    if (!read_ready)
    begin
      timeout_count++;
      $display("timeout: read of address %h was not accepted within %0d cycles",
               addr, read_timeout);
      @(negedge clk);
      read_valid = 1'b0;
    end
    else
    begin
      @(posedge clk);
      @(negedge clk);
      read_valid = 1'b0;
      // leaves room for the install cycle
      @(negedge clk);
    end
  endtask

  task automatic run_behaviors();
    addr_t       addr_a;
    addr_t       addr_b;
    addr_t       addr;
    word_t       old_word;
    logic [31:0] bits;
    int          n;
    for (n = 0; n < mem_words; n++)
    begin
      write_word(addr_t'(n), fill_pattern(addr_t'(n)));
    end

    // miss then hit on the same address
    addr_a = 10'h1a6;
    do_read(addr_a);
    do_read(addr_a);

    for (n = 0; n < words_per_line; n++)
    begin
      do_read({addr_a[addr_bits-1:offset_bits], offset_t'(n)});
    end

    // same index with another tag
    addr_b = addr_a ^ (addr_t'(1) << (offset_bits + index_bits));
    for (n = 0; n < 3; n++)
    begin
      do_read(addr_b);
      do_read(addr_a);
    end

    // cached copy goes stale until a flush
    do_read(addr_a);
    old_word = ref_mem[addr_a];
    write_word(addr_a, ~old_word);
    do_read(addr_a);
    flush_cache();
    do_read(addr_a);

    for (n = 0; n < random_reads; n++)
    begin
      take_bits(2, bits);
      if (bits == 0)
      begin
        take_bits(addr_bits, bits);
        addr = addr_t'(bits);
        take_bits(word_bits, bits);
        write_word(addr, word_t'(bits));
      end
      take_bits(4, bits);
      if (bits == 0)
      begin
        flush_cache();
      end
      take_bits(addr_bits, bits);
      addr = addr_t'(bits);
      take_bits(1, bits);
      // narrow window half the time for more hits
      if (bits[0])
      begin
        addr[addr_bits-1:offset_bits+index_bits+1] = '0;
      end
      do_read(addr);
    end
  endtask

  initial
  begin
    int cycles;
    read_valid     = 1'b0;
    read_addr      = '0;
    flush          = 1'b0;
    mem_write_en   = 1'b0;
    mem_write_addr = '0;
    mem_write_data = '0;
    lfsr_state     = lfsr_seed;
    expect_hit     = 1'b0;
    expected_word  = '0;
    cached_valid   = '0;
    error_count    = 0;
    timeout_count  = 0;
    read_count     = 0;
    hit_count      = 0;
    cycles         = 0;
    while (reset !== 1'b0 && cycles < reset_timeout)
    begin
      @(negedge clk);
      cycles++;
    end
    if (reset !== 1'b0)
    begin
      timeout_count++;
      $display("timeout: reset was never released");
    end
    else
    begin
      run_behaviors();
    end
    finish_run();
  end

endmodule

`default_nettype wire

// File: src.f
common/cache_pkg.sv
common/line_fetch_if.sv
cache/cache_direct_mapped.sv
hw/line_memory.sv
hw/cache_subsystem_top.sv
sim/clock_gen.sv
sim/cache_tb.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
  --top-module cache_tb -o Vcache_tb -f src.f

out=$(./obj_dir/Vcache_tb 2>&1) || { printf '%s\n' "$out"; exit 1; }
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx "SIMULATION PASSED"; then
  exit 0
else
  exit 1
fi
